// ==== build.f ====
+incdir+common
common/dac_pkg.sv
common/spi_tick_if.sv
dac_spi/spi_clock_gen.sv
dac_spi/xfer_ctrl.sv
dac_spi/word_store.sv
dac_spi/frame_shifter.sv
source/dac_auto_update.sv
test/dac_auto_update_assert.sv
test/tb_dac_auto_update.sv

// ==== common/dac_defs.svh ====
// sizes assume a 16-bit AD5662-style part; divider width sets sclk to clk/2**width
`ifndef DAC_DEFS_SVH
`define DAC_DEFS_SVH

// 4 bits -> one sclk period per 16 system clocks
`define DAC_DIV_W 4

// pad + mode + data
`define DAC_FRAME_BITS 24

// midscale code, matches the value the DAC powers up near
`define DAC_RESET_DATA 16'd32767

`endif

// ==== common/dac_pkg.sv ====
// frame layout assumes the AD5662 24-bit word; pad bits must be zero when loaded
package dac_pkg;

  `include "dac_defs.svh"

  // power-down control bits, DB17:DB16 of the DAC frame
  typedef enum logic [1:0] {
    pd_normal   = 2'b00,  // normal operation
    pd_1k_gnd   = 2'b01,  // output 1 k to ground
    pd_100k_gnd = 2'b10,  // output 100 k to ground
    pd_tristate = 2'b11   // output three-state
  } pd_mode_e;

  typedef struct packed {
    logic [5:0]  pad;   // don't-care bits, sent as zero
    pd_mode_e    pd;
    logic [15:0] data;  // DAC code, msb first on the wire
  } dac_fields_t;

  // one frame word, loaded by field and shifted as a plain vector
  typedef union packed {
    logic [`DAC_FRAME_BITS-1:0] raw;
    dac_fields_t                f;
  } dac_frame_t;

  // transfer sequencer count, advanced once per serial period
  typedef logic [4:0] xfer_state_t;

  localparam xfer_state_t st_ready    = 5'd0;   // idle, waiting for a change
  localparam xfer_state_t st_capture  = 5'd1;   // live inputs copied into the store
  localparam xfer_state_t st_sync_hi  = 5'd2;   // sync pulse, shifter loaded
  localparam xfer_state_t st_sync_end = 5'd27;  // last bit done, sync back high

endpackage

// ==== common/spi_tick_if.sv ====
// plain strobes and levels only, no handshake; sena and hena are one-clock pulses
`timescale 1ns/10ps

interface spi_tick_if;

  logic run;      // divider enable, from the sequencer
  logic sclk_go;  // sclk allowed to toggle
  logic sena;     // full-count strobe, state step and sclk rise
  logic hena;     // half-count strobe, sclk fall

  modport gen (
    input  run,
    input  sclk_go,
    output sena,
    output hena
  );

  modport ctrl (
    output run,
    output sclk_go,
    input  sena
  );

  modport shift (
    input sena
  );

endinterface

// ==== dac_spi/frame_shifter.sv ====
// msb first, zero fill; mosi lags the register top bit by one sena period
`timescale 1ns/10ps

module frame_shifter
  import dac_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  spi_tick_if.shift  tick,
  input  logic       load,
  input  dac_frame_t stored,
  output logic       mosi
);

  dac_frame_t shift_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      shift_q.raw <= '0;
      mosi        <= 1'b0;
    end else if (tick.sena) begin
      mosi <= shift_q.raw[`DAC_FRAME_BITS-1];  // old top bit out
      if (load) begin
        shift_q.f.pad  <= stored.f.pad;
        shift_q.f.pd   <= stored.f.pd;
        shift_q.f.data <= stored.f.data;
      end else begin
        // empty after a frame, so mosi idles low
        shift_q.raw <= {shift_q.raw[`DAC_FRAME_BITS-2:0], 1'b0};
      end
    end
  end

endmodule

// ==== dac_spi/spi_clock_gen.sv ====
// divider phase is not cleared between frames, so sclk start phase varies per frame
`timescale 1ns/10ps

module spi_clock_gen (
  input  logic       clk,
  input  logic       rst,
  spi_tick_if.gen    tick,
  output logic       sclk
);

  localparam logic [`DAC_DIV_W-1:0] cnt_full = '1;  // last count of a period
  localparam logic [`DAC_DIV_W-1:0] cnt_half = 1'b1 << (`DAC_DIV_W - 1);

  logic [`DAC_DIV_W-1:0] cnt_q;
  logic                  full;
  logic                  half;

  assign full = (cnt_q == cnt_full);
  assign half = (cnt_q == cnt_half);

  // free-running only while a frame is pending or in flight
  always_ff @(posedge clk) begin
    if (rst) begin
      cnt_q <= '0;
    end else if (tick.run) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // strobes lag the count by one clock; gated so a parked count at full
  // cannot fire a pulse every clock
  always_ff @(posedge clk) begin
    if (rst) begin
      tick.sena <= 1'b0;
      tick.hena <= 1'b0;
    end else begin
      tick.sena <= tick.run & full;
      tick.hena <= tick.run & half;
    end
  end

  // sclk idles high, falls mid-period, rises with the state step
  always_ff @(posedge clk) begin
    if (rst) begin
      sclk <= 1'b1;
    end else if (!tick.sclk_go) begin
      sclk <= 1'b1;                 // parked high outside the data bits
    end else if (tick.hena) begin
      sclk <= 1'b0;                 // DAC samples mosi here
    end else if (tick.sena) begin
      sclk <= 1'b1;
    end
  end

endmodule

// ==== dac_spi/word_store.sv ====
// holds the last programmed value; inputs taken only on capture, not queued
`timescale 1ns/10ps

module word_store
  import dac_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic [15:0] dat,
  input  pd_mode_e    pd,
  input  logic        capture,
  output logic        changed,
  output dac_frame_t  stored
);

  logic [15:0] data_q;  // copy of what the DAC holds
  pd_mode_e    pd_q;

  // reset value mirrors the DAC so nothing is sent for midscale/normal
  always_ff @(posedge clk) begin
    if (rst) begin
      data_q <= `DAC_RESET_DATA;
      pd_q   <= pd_normal;
    end else if (capture) begin
      data_q <= dat;
      pd_q   <= pd;
    end
  end

  assign changed = (dat != data_q) | (pd != pd_q);  // live level, no edge detect

  always_comb begin
    stored        = '0;  // pad bits stay zero
    stored.f.pd   = pd_q;
    stored.f.data = data_q;
  end

endmodule

// ==== dac_spi/xfer_ctrl.sv ====
// one frame is 28 sena steps; input changes seen only in st_ready are acted on
`timescale 1ns/10ps

module xfer_ctrl
  import dac_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  spi_tick_if.ctrl   tick,
  input  logic       changed,
  output logic       capture,
  output logic       load,
  output logic       sync_n
);

  xfer_state_t state_q;
  xfer_state_t state_nxt;
  logic        sclk_go_q;

  always_comb begin
    case (state_q)
      st_ready:    state_nxt = changed ? st_capture : st_ready;  // hold until new data
      st_sync_end: state_nxt = st_ready;
      default:     state_nxt = xfer_state_t'(state_q + 1'b1);
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= st_ready;
    end else if (tick.sena) begin
      state_q <= state_nxt;
    end
  end

  // sync_n is kept high for one period after st_sync_end, so the divider
  // has to keep running until the sena that drops it again
  assign tick.run = changed | (state_q != st_ready) | sync_n;

  assign capture = tick.sena & (state_q == st_capture);  // store takes dat/pd
  assign load    = tick.sena & (state_q == st_sync_hi);  // shifter takes the frame

  // high period before the frame and after the last bit, low otherwise
  always_ff @(posedge clk) begin
    if (rst) begin
      sync_n <= 1'b0;               // low when idle, saves power in the DAC
    end else if (tick.sena) begin
      sync_n <= (state_q == st_sync_hi) | (state_q == st_sync_end);
    end
  end

  // sampled on sena so it covers the periods after st_sync_hi+1 through
  // st_sync_end, giving exactly 24 falling sclk edges while sync_n is low
  always_ff @(posedge clk) begin
    if (rst) begin
      sclk_go_q <= 1'b0;
    end else if (tick.sena) begin
      sclk_go_q <= (state_q > st_sync_hi) & (state_q < st_sync_end);
    end
  end

  assign tick.sclk_go = sclk_go_q;

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 -f build.f --top-module tb_dac_auto_update \
  || { echo "verilator compile failed"; exit 1; }
./obj_dir/Vtb_dac_auto_update > sim.log 2>&1 \
  || echo "FAIL: see errors above" >> sim.log
cat sim.log
grep -q "FAIL: see errors above" sim.log && { echo "simulation failed"; exit 1; }
echo "simulation passed"
exit 0

// ==== source/dac_auto_update.sv ====
// dat/pd are plain levels; changes arriving mid-frame are dropped until idle
`timescale 1ns/10ps

module dac_auto_update
  import dac_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic [15:0] dat,
  input  logic [1:0]  pd,
  output logic        sclk,
  output logic        mosi,
  output logic        sync_n
);

  logic       changed;  // store differs from inputs
  logic       capture;
  logic       load;
  dac_frame_t stored;

  spi_tick_if tick ();  // divider strobes and run request

  spi_clock_gen i_spi_clock_gen (
    .clk  (clk),
    .rst  (rst),
    .tick (tick.gen),
    .sclk (sclk)
  );

  xfer_ctrl i_xfer_ctrl (
    .clk     (clk),
    .rst     (rst),
    .tick    (tick.ctrl),
    .changed (changed),
    .capture (capture),
    .load    (load),
    .sync_n  (sync_n)
  );

  word_store i_word_store (
    .clk     (clk),
    .rst     (rst),
    .dat     (dat),
    .pd      (pd_mode_e'(pd)),  // all four codes are valid modes
    .capture (capture),
    .changed (changed),
    .stored  (stored)
  );

  frame_shifter i_frame_shifter (
    .clk    (clk),
    .rst    (rst),
    .tick   (tick.shift),
    .load   (load),
    .stored (stored),
    .mosi   (mosi)
  );

endmodule

// ==== test/dac_auto_update_assert.sv ====
// checks are off while rst is high; sena is taken from the divider strobe inside the top level
`timescale 1ns/10ps

module dac_auto_update_assert (
  input logic clk,
  input logic rst,
  input logic sena,    // divider full-count strobe
  input logic sclk,
  input logic mosi,
  input logic sync_n
);

  // no sclk pulses outside the shifting window
  sclk_idle_high: assert property (@(posedge clk) disable iff (rst)
    sync_n |-> sclk)
    else $error("sclk low while sync_n high");

  // mosi settles a half period before the falling sclk edge
  mosi_on_sena: assert property (@(posedge clk) disable iff (rst)
    !$stable(mosi) |-> $past(sena))
    else $error("mosi changed without a preceding sena");

  sync_on_sena: assert property (@(posedge clk) disable iff (rst)
    !$stable(sync_n) |-> $past(sena))   // both sync edges are state steps
    else $error("sync_n changed without a preceding sena");

endmodule

bind dac_auto_update dac_auto_update_assert i_dac_auto_update_assert (
  .clk    (clk),
  .rst    (rst),
  .sena   (tick.sena),
  .sclk   (sclk),
  .mosi   (mosi),
  .sync_n (sync_n)
);

// ==== test/tb_dac_auto_update.sv ====
// frames are decoded from the pins only; assumes sync_n idles low and sclk idles high
`timescale 1ns/10ps
`include "dac_defs.svh"

module tb_dac_auto_update;

  localparam int clk_half      = 5;
  localparam int frame_clks    = 28 * 16;         // 28 sena steps of 16 clocks
  localparam int frame_limit   = 2 * frame_clks;  // worst start phase plus margin
  localparam int quiet_clks    = frame_clks + 64; // a stray frame would finish inside this
  localparam int n_frames      = 25;
  localparam int n_quiet       = 6;
  localparam int watchdog_clks = (n_frames * frame_clks + n_quiet * quiet_clks) * 2;

  logic        clk = 1'b0;
  logic        rst;
  logic [15:0] dat;
  logic [1:0]  pd;
  logic        sclk;
  logic        mosi;
  logic        sync_n;

  logic [23:0] frames[$];    // decoded words, arrival order
  int          rd_idx;       // next unread frame
  logic [23:0] rx_shift;
  int          rx_bits;
  int          stray_errs;   // partial frames seen by the decoder
  int          errors;
  int          checks;
  int          tests_run;
  int          seed;
  logic [15:0] last_dat;     // value the DAC should hold now
  logic [1:0]  last_pd;

  always #clk_half clk = ~clk;

  dac_auto_update i_dac_auto_update (
    .clk    (clk),
    .rst    (rst),
    .dat    (dat),
    .pd     (pd),
    .sclk   (sclk),
    .mosi   (mosi),
    .sync_n (sync_n)
  );

  // DAC side: shift mosi on falling sclk while sync_n low, msb first
  always @(negedge sclk or posedge sync_n) begin
    if (sync_n) begin
      if (rx_bits != 0) begin
        $display("decoder saw %0d sclk falls that did not make a whole frame", rx_bits);
        stray_errs = stray_errs + 1;
      end
      rx_bits = 0;
    end else if (!rst) begin
      rx_shift = {rx_shift[22:0], mosi};
      rx_bits  = rx_bits + 1;
      if (rx_bits == `DAC_FRAME_BITS) begin
        frames.push_back(rx_shift);
        rx_bits = 0;
      end
    end
  end

  function automatic logic [23:0] frame_word(input logic [15:0] d, input logic [1:0] p);
    frame_word = {6'b000000, p, d};  // pad, mode, data
  endfunction

  function automatic int pending();
    pending = frames.size() - rd_idx;
  endfunction

  task automatic check(input string name, input logic [23:0] expected,
                       input logic [23:0] actual);
    checks = checks + 1;
    if (expected !== actual) begin
      $display("Error %s: expected %h, actual %h", name, expected, actual);
      errors = errors + 1;
    end
  endtask

  task automatic drive(input logic [15:0] d, input logic [1:0] p);
    @(posedge clk);
    dat <= d;
    pd  <= p;
  endtask

  task automatic wait_frame(input string name, output logic [23:0] word, output logic ok);
    int n;
    n    = 0;
    word = '0;
    while (pending() == 0 && n < frame_limit) begin
      @(negedge clk);
      n = n + 1;
    end
    ok = (pending() != 0);
    if (ok) begin
      word   = frames[rd_idx];
      rd_idx = rd_idx + 1;
    end else begin
      $display("%s: no frame arrived within %0d clocks", name, frame_limit);
      errors = errors + 1;
    end
  endtask

  // sync pulse seen, then sync_n low again, so bits are on the wire
  task automatic wait_shifting(input string name);
    int   n;
    logic seen_hi;
    n       = 0;
    seen_hi = 1'b0;
    while (!(seen_hi && !sync_n) && n < frame_limit) begin
      @(negedge clk);
      if (sync_n) begin
        seen_hi = 1'b1;
      end
      n = n + 1;
    end
    if (!(seen_hi && !sync_n)) begin
      $display("%s: frame never started shifting within %0d clocks", name, frame_limit);
      errors = errors + 1;
    end
  endtask

  task automatic expect_quiet(input string name, input int clks);
    repeat (clks) @(negedge clk);
    check(name, 24'd0, 24'(pending()));  // count of unexpected frames
    rd_idx = frames.size();
  endtask

  task automatic finish_test(input string name, input int base);
    tests_run = tests_run + 1;
    $display("test %s finished with %0d errors", name, errors - base);
  endtask

  task automatic test_idle();
    int          base;
    logic [23:0] bad;
    base = errors;
    bad  = '0;
    drive(`DAC_RESET_DATA, 2'b00);
    repeat (500) begin
      @(negedge clk);
      if (sync_n !== 1'b0 || sclk !== 1'b1) begin
        bad = bad + 24'd1;
      end
    end
    check("idle pin samples off", 24'd0, bad);
    check("idle frame count", 24'd0, 24'(pending()));
    finish_test("idle after reset", base);
  endtask

  task automatic test_single();
    int          base;
    logic [23:0] w;
    logic        ok;
    base = errors;
    drive(16'h1234, 2'b00);
    wait_frame("single write", w, ok);
    if (ok) begin
      check("single write", frame_word(16'h1234, 2'b00), w);
    end
    expect_quiet("single write extra frames", quiet_clks);
    last_dat = 16'h1234;
    last_pd  = 2'b00;
    finish_test("single write", base);
  endtask

  task automatic test_pd();
    int          base;
    logic [23:0] w;
    logic        ok;
    base = errors;
    drive(last_dat, 2'b10);  // mode only, data unchanged
    wait_frame("power-down mode", w, ok);
    if (ok) begin
      check("power-down mode", frame_word(last_dat, 2'b10), w);
    end
    expect_quiet("power-down extra frames", quiet_clks);
    last_pd = 2'b10;
    finish_test("power-down mode", base);
  endtask

  task automatic test_mid_frame();
    int          base;
    logic [23:0] w;
    logic        ok;
    base = errors;
    drive(16'hA5A5, last_pd);
    wait_shifting("mid-frame change");
    drive(16'h1111, last_pd);  // three values inside 120 clocks of a 384-clock window
    repeat (40) @(posedge clk);
    drive(16'h2222, last_pd);
    repeat (40) @(posedge clk);
    drive(16'h3333, last_pd);
    wait_frame("mid-frame first", w, ok);
    if (ok) begin
      check("mid-frame first", frame_word(16'hA5A5, last_pd), w);
    end
    wait_frame("mid-frame second", w, ok);
    if (ok) begin
      check("mid-frame second", frame_word(16'h3333, last_pd), w);
    end
    expect_quiet("mid-frame extra frames", quiet_clks);
    last_dat = 16'h3333;
    finish_test("changes during a frame", base);
  endtask

  task automatic test_random();
    int          base;
    logic [31:0] r;
    logic [15:0] d;
    logic [1:0]  p;
    logic [23:0] w;
    logic        ok;
    base = errors;
    for (int i = 0; i < 20; i++) begin
      r = $random(seed);
      d = r[15:0];
      p = r[17:16];
      if ({p, d} == {last_pd, last_dat}) begin
        d = d ^ 16'h0001;  // must differ or nothing is sent
      end
      drive(d, p);
      wait_frame($sformatf("random write %0d", i), w, ok);
      if (ok) begin
        check($sformatf("random write %0d", i), frame_word(d, p), w);
      end
      last_dat = d;
      last_pd  = p;
    end
    expect_quiet("random extra frames", quiet_clks);  // trailing sync pulse done, back to idle
    finish_test("random writes", base);
  endtask

  task automatic test_no_repeat();
    int          base;
    logic [15:0] v;
    logic [23:0] w;
    logic        ok;
    base = errors;
    v    = (last_dat == 16'h5A5A) ? 16'hC3C3 : 16'h5A5A;
    drive(v, last_pd);
    wait_shifting("no repeat send");
    drive(~v, last_pd);  // brief excursion, back before the frame ends
    repeat (40) @(posedge clk);
    drive(v, last_pd);
    wait_frame("no repeat send", w, ok);
    if (ok) begin
      check("no repeat send", frame_word(v, last_pd), w);
    end
    expect_quiet("no repeat extra frames", quiet_clks);
    finish_test("no repeat send", base);
  endtask

  initial begin
    #(watchdog_clks * 2 * clk_half);
    $display("watchdog expired after %0d clocks, tests did not finish", watchdog_clks);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    rst        = 1'b1;
    dat        = `DAC_RESET_DATA;
    pd         = 2'b00;
    rd_idx     = 0;
    rx_shift   = '0;
    rx_bits    = 0;
    stray_errs = 0;
    errors     = 0;
    checks     = 0;
    tests_run  = 0;
    seed       = 32'h8367_9bed;
    last_dat   = `DAC_RESET_DATA;
    last_pd    = 2'b00;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    test_idle();
    test_single();
    test_pd();
    test_mid_frame();
    test_random();
    test_no_repeat();
    errors = errors + stray_errs;
    $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule
